/* frame_hold_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_hold_timer import frame_pkg::*; (
    input  logic clk_sys,
    input  logic rst_n,
    input  logic hold_start,
    output logic hold_done
);

    logic [HOLD_W-1:0] cnt;     // Zero means idle

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (hold_start) begin
            cnt <= HOLD_W'(RST_HOLD);   // Restart also while counting
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    // Last counting cycle, a restart in the same cycle wins
    assign hold_done = (cnt == HOLD_W'(1)) && !hold_start;

endmodule

`default_nettype wire

/* frame_pkg.sv */
`default_nettype none

package frame_pkg;

    localparam int COLORW        = 4;   // Colour bits per channel from the core
    localparam int RST_HOLD      = 16;  // Game reset hold in clk_sys cycles
    localparam int ROM_AW        = 22;  // Host byte address width
    localparam int STATUS_FX_LSB = 3;   // Scanline level field in status
    localparam int HOLD_W        = 5;   // Must hold RST_HOLD

    // Native video as the core produces it
    typedef struct packed {
        logic [COLORW-1:0] r;
        logic [COLORW-1:0] g;
        logic [COLORW-1:0] b;
        logic              hs;
        logic              vs;
        logic              lhbl;    // Low during horizontal blank
        logic              lvbl;    // Low during vertical blank
    } game_video_t;

    // Video ready for the output stage
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic       hs;
        logic       vs;
        logic       de;
    } video_t;

    // One byte strobe from the host download
    typedef struct packed {
        logic [ROM_AW-1:0] addr;
        logic [7:0]        data;
        logic              wr;
    } ioctl_t;

    // Word write towards the memory port
    typedef struct packed {
        logic [ROM_AW-2:0] addr;    // Word address
        logic [15:0]       data;
        logic [1:0]        mask;    // Active low, bit 1 masks the high byte
        logic              we;
    } prog_t;

    typedef enum logic [1:0] {
        ST_HOLD,
        ST_LOAD,
        ST_RUN
    } rst_state_e;

endpackage

`default_nettype wire

/* frame_rom_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_rom_loader import frame_pkg::*; (
    input  logic   clk_sys,
    input  logic   rst_n,
    input  ioctl_t ioctl,
    input  logic   downloading,
    output prog_t  prog
);

    logic [7:0]        even_byte;   // Low byte waiting for its partner
    logic [ROM_AW-2:0] even_addr;
    logic              pending;
    logic              dl_prev;
    logic              byte_wr;
    logic              word_go;
    logic              flush_go;

    logic [ROM_AW-2:0] word_addr;
    logic [15:0]       word_data;
    logic [1:0]        word_mask;
    logic              word_we;

    assign byte_wr  = ioctl.wr & downloading;
    assign word_go  = byte_wr & ioctl.addr[0];     // Odd byte closes a word
    assign flush_go = dl_prev & ~downloading & pending;

    // Byte and word payload
    always_ff @(posedge clk_sys) begin
        if (byte_wr && !ioctl.addr[0]) begin
            even_byte <= ioctl.data;
            even_addr <= ioctl.addr[ROM_AW-1:1];
        end
        if (word_go) begin
            word_addr <= ioctl.addr[ROM_AW-1:1];
            word_data <= {ioctl.data, even_byte};
            word_mask <= 2'b00;
        end else if (flush_go) begin
            word_addr <= even_addr;
            word_data <= {8'h00, even_byte};
            word_mask <= 2'b10;     // Lone low byte
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            pending <= 1'b0;
            dl_prev <= 1'b0;
            word_we <= 1'b0;
        end else begin
            dl_prev <= downloading;
            word_we <= word_go | flush_go;
            if (byte_wr) begin
                pending <= ~ioctl.addr[0];
            end else if (flush_go) begin
                pending <= 1'b0;
            end
        end
    end

    assign prog = '{addr: word_addr, data: word_data, mask: word_mask, we: word_we};

endmodule

`default_nettype wire

/* frame_rst_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_rst_fsm import frame_pkg::*; (
    input  logic clk_sys,
    input  logic rst_n,
    input  logic downloading,
    input  logic rst_req,
    input  logic hold_done,
    output logic hold_start,
    output logic game_rst_n
);

    rst_state_e state;
    rst_state_e state_nx;
    logic       dl_prev;
    logic       dl_rise;
    logic       dl_fall;

    assign dl_rise = downloading & ~dl_prev;
    assign dl_fall = ~downloading & dl_prev;

    always_comb begin
        state_nx = state;
        if (dl_rise) begin
            state_nx = ST_LOAD;     // A new download wins from any state
        end else begin
            case (state)
                ST_HOLD: begin
                    if (hold_done) begin
                        state_nx = ST_RUN;
                    end
                end
                ST_LOAD: begin
                    if (dl_fall) begin
                        state_nx = ST_HOLD;
                    end
                end
                ST_RUN: begin
                    if (rst_req) begin
                        state_nx = ST_HOLD;
                    end
                end
                default: state_nx = ST_HOLD;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            state      <= ST_HOLD;
            dl_prev    <= 1'b0;
            hold_start <= 1'b1;     // Timer starts right after board reset
            game_rst_n <= 1'b0;
        end else begin
            state      <= state_nx;
            dl_prev    <= downloading;
            hold_start <= (state_nx == ST_HOLD) && (state != ST_HOLD);
            game_rst_n <= (state_nx == ST_RUN);
        end
    end

endmodule

`default_nettype wire

/* frame_video_out.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_video_out import frame_pkg::*; (
    input  logic        clk_sys,
    input  logic        rst_n,
    input  logic        pxl_cen,
    input  game_video_t game,
    input  logic [1:0]  fx_level,
    output video_t      video,
    output logic        video_cen
);

    logic   hs_prev;
    logic   vs_prev;
    logic   line_odd;       // Parity of the line in progress
    logic   line_odd_now;
    logic   de;
    logic   [1:0] dim;
    video_t vid_nx;

    // Repeat the colour into 8 bits, then darken by sh
    function automatic logic [7:0] widen(input logic [COLORW-1:0] c, input logic [1:0] sh);
        logic [7:0] full;
        full = {c, c};
        return full >> sh;
    endfunction

    always_comb begin
        // Parity including an edge in this very cycle
        if (game.vs && !vs_prev) begin
            line_odd_now = 1'b0;    // First line after vsync is even
        end else if (game.hs && !hs_prev) begin
            line_odd_now = ~line_odd;
        end else begin
            line_odd_now = line_odd;
        end

        de  = game.lhbl & game.lvbl;
        dim = line_odd_now ? fx_level : 2'd0;

        vid_nx.r  = de ? widen(game.r, dim) : 8'h00;
        vid_nx.g  = de ? widen(game.g, dim) : 8'h00;
        vid_nx.b  = de ? widen(game.b, dim) : 8'h00;
        vid_nx.hs = game.hs;
        vid_nx.vs = game.vs;
        vid_nx.de = de;
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            hs_prev   <= 1'b0;
            vs_prev   <= 1'b0;
            line_odd  <= 1'b0;
            video     <= '0;
            video_cen <= 1'b0;
        end else begin
            hs_prev   <= game.hs;
            vs_prev   <= game.vs;
            line_odd  <= line_odd_now;
            video     <= vid_nx;
            video_cen <= pxl_cen;   // Keeps the enable aligned with the pixel
        end
    end

endmodule

`default_nettype wire

/* mister_frame.f */
frame_pkg.sv
frame_hold_timer.sv
frame_rst_fsm.sv
frame_rom_loader.sv
frame_video_out.sv
mister_frame.sv
mister_frame_chk.sv
mister_frame_mon.sv
mister_frame_tb.sv

/* mister_frame.sv */
`timescale 1ns/1ps
`default_nettype none

module mister_frame import frame_pkg::*; (
    input  logic        clk_sys,
    input  logic        rst_n,
    // ROM download
    input  ioctl_t      ioctl,
    input  logic        downloading,
    output prog_t       prog,
    // Game reset
    input  logic        rst_req,
    output logic        game_rst_n,
    // Host settings
    input  logic [31:0] status,
    // Video
    input  logic        pxl_cen,
    input  game_video_t game,
    output video_t      video,
    output logic        video_cen
);

    logic       hold_start;
    logic       hold_done;
    logic [1:0] fx_level;

    assign fx_level = status[STATUS_FX_LSB +: 2];  // Scanline strength from the OSD

    frame_rst_fsm u_rst_fsm (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .rst_req     ( rst_req     ),
        .hold_done   ( hold_done   ),
        .hold_start  ( hold_start  ),
        .game_rst_n  ( game_rst_n  )
    );

    frame_hold_timer u_hold_timer (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .hold_start  ( hold_start  ),
        .hold_done   ( hold_done   )
    );

    frame_rom_loader u_rom_loader (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .ioctl       ( ioctl       ),
        .downloading ( downloading ),
        .prog        ( prog        )
    );

    frame_video_out u_video_out (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .pxl_cen     ( pxl_cen     ),
        .game        ( game        ),
        .fx_level    ( fx_level    ),
        .video       ( video       ),
        .video_cen   ( video_cen   )
    );

endmodule

`default_nettype wire

/* mister_frame_cases.txt */
# kind  p1 (hex)        p2 (hex)
# D     start address   byte count
# V     effect level    line count
# R     reset request, no parameters
D 000000 8
D 000100 5
V 0 3
V 1 4
V 2 4
V 3 5
R
D 001000 10
D 002002 1
V 2 2
R
D 003ff0 7
V 1 3

/* mister_frame_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module mister_frame_chk import frame_pkg::*; (
    input logic   clk_sys,
    input logic   rst_n,
    input logic   downloading,
    input logic   game_rst_n,
    input prog_t  prog,
    input video_t video
);

    int fail_count = 0;

    // Game stays in reset while the ROM is loading
    dl_holds_rst: assert property (@(posedge clk_sys) disable iff (!rst_n)
        downloading |=> !game_rst_n)
        else begin
            $error("game_rst_n high one cycle after downloading");
            fail_count++;
        end

    blank_is_black: assert property (@(posedge clk_sys) disable iff (!rst_n)
        !video.de |-> (video.r == 8'h00 && video.g == 8'h00 && video.b == 8'h00))
        else begin
            $error("colour not black while video.de is low");
            fail_count++;
        end

    mask_legal: assert property (@(posedge clk_sys) disable iff (!rst_n)
        prog.we |-> (prog.mask == 2'b00 || prog.mask == 2'b10))
        else begin
            $error("prog.mask %b on a write", prog.mask);
            fail_count++;
        end

endmodule

`default_nettype wire

/* mister_frame_mon.sv */
`timescale 1ns/1ps
`default_nettype none

module mister_frame_mon import frame_pkg::*; (
    input  logic        clk_sys,
    input  logic        rst_n,
    input  ioctl_t      ioctl,
    input  logic        downloading,
    input  logic        rst_req,
    input  logic [31:0] status,
    input  logic        pxl_cen,
    input  game_video_t game,
    input  prog_t       prog,
    input  logic        game_rst_n,
    input  video_t      video,
    input  logic        video_cen,
    output int          err_count
);

    int                errors = 0;
    logic              armed = 1'b0;    // Outputs are defined after one reset edge
    rst_state_e        st;
    int                hold_left;       // 1 means release on this edge
    logic              exp_rst_n;
    logic              dl_q;
    logic              pend;
    logic [7:0]        pend_byte;
    logic [ROM_AW-2:0] pend_addr;
    prog_t             exp_prog;
    logic              hs_q;
    logic              vs_q;
    logic              odd;
    video_t            exp_video;
    logic              exp_cen;

    assign err_count = errors;

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("** Error: %s expected %0h got %0h at %0t", name, exp, act, $time);
            errors++;
        end
    endtask

    // Times 0x11 repeats the nibble
    function automatic logic [7:0] expand(input logic [COLORW-1:0] c, input logic [1:0] lvl);
        logic [7:0] full;
        full = 8'h11 * {4'h0, c};
        return full >> lvl;
    endfunction

    always @(posedge clk_sys) begin
        logic       odd_now;
        logic       de;
        logic [1:0] lvl;
        if (armed) begin
            compare("game_rst_n", 32'(exp_rst_n), 32'(game_rst_n));
            compare("prog.we", 32'(exp_prog.we), 32'(prog.we));
            if (exp_prog.we) begin
                compare("prog.addr", 32'(exp_prog.addr), 32'(prog.addr));
                compare("prog.mask", 32'(exp_prog.mask), 32'(prog.mask));
                compare("prog.data", 32'(exp_prog.data),
                        32'(exp_prog.mask[1] ? {8'h00, prog.data[7:0]} : prog.data));
            end
            compare("video", 32'(exp_video), 32'(video));
            compare("video_cen", 32'(exp_cen), 32'(video_cen));
        end
        if (!rst_n) begin
            armed     <= 1'b1;
            st        <= ST_HOLD;
            hold_left <= RST_HOLD + 1;  // Timer loads on the first edge out of reset
            exp_rst_n <= 1'b0;
            dl_q      <= 1'b0;
            pend      <= 1'b0;
            exp_prog  <= '0;
            hs_q      <= 1'b0;
            vs_q      <= 1'b0;
            odd       <= 1'b0;
            exp_video <= '0;
            exp_cen   <= 1'b0;
        end else begin
            dl_q <= downloading;
            if (downloading && !dl_q) begin
                st        <= ST_LOAD;
                exp_rst_n <= 1'b0;
            end else if (st == ST_HOLD) begin
                if (hold_left == 1) begin
                    st        <= ST_RUN;
                    exp_rst_n <= 1'b1;
                end else begin
                    hold_left <= hold_left - 1;
                end
            end else if ((st == ST_LOAD && dl_q && !downloading) || (st == ST_RUN && rst_req)) begin
                st        <= ST_HOLD;
                hold_left <= RST_HOLD + 1;  // Extra edge to start the timer
                exp_rst_n <= 1'b0;
            end

            // Byte packing
            exp_prog.we <= 1'b0;
            if (ioctl.wr && downloading) begin
                if (!ioctl.addr[0]) begin
                    pend      <= 1'b1;
                    pend_byte <= ioctl.data;
                    pend_addr <= ioctl.addr[ROM_AW-1:1];
                end else begin
                    pend     <= 1'b0;
                    exp_prog <= '{addr: ioctl.addr[ROM_AW-1:1], data: {ioctl.data, pend_byte},
                                  mask: 2'b00, we: 1'b1};
                end
            end else if (dl_q && !downloading && pend) begin
                pend     <= 1'b0;
                exp_prog <= '{addr: pend_addr, data: {8'h00, pend_byte}, mask: 2'b10, we: 1'b1};
            end

            // Line parity and dimming
            if (game.vs && !vs_q) odd_now = 1'b0;
            else if (game.hs && !hs_q) odd_now = ~odd;
            else odd_now = odd;
            lvl = odd_now ? status[STATUS_FX_LSB +: 2] : 2'd0;
            de  = game.lhbl && game.lvbl;
            hs_q         <= game.hs;
            vs_q         <= game.vs;
            odd          <= odd_now;
            exp_video.r  <= de ? expand(game.r, lvl) : 8'h00;
            exp_video.g  <= de ? expand(game.g, lvl) : 8'h00;
            exp_video.b  <= de ? expand(game.b, lvl) : 8'h00;
            exp_video.hs <= game.hs;
            exp_video.vs <= game.vs;
            exp_video.de <= de;
            exp_cen      <= pxl_cen;
        end
    end

endmodule

`default_nettype wire

/* mister_frame_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mister_frame_tb import frame_pkg::*; ();

    logic        clk_sys = 1'b0;
    logic        rst_n;
    ioctl_t      ioctl;
    logic        downloading;
    logic        rst_req;
    logic [31:0] status;
    logic        pxl_cen;
    game_video_t game;
    prog_t       prog;
    logic        game_rst_n;
    video_t      video;
    logic        video_cen;
    int          mon_errors;
    int          tb_errors = 0;
    int          limit_cycles = 0;
    logic [7:0]  case_kind[$];
    logic [31:0] case_p1[$];
    logic [31:0] case_p2[$];

    always #10 clk_sys = ~clk_sys;

    mister_frame dut (.*);

    mister_frame_mon mon (.*, .err_count(mon_errors));

    bind mister_frame mister_frame_chk chk (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .game_rst_n  ( game_rst_n  ),
        .prog        ( prog        ),
        .video       ( video       )
    );

    function automatic int error_total();
        return mon_errors + tb_errors + dut.chk.fail_count;
    endfunction

    // Rough cycle budget of one case, used by the watchdog
    function automatic int case_cycles(input logic [7:0] kind, input logic [31:0] p2);
        if (kind == "D") return 2 * int'(p2) + 2 * RST_HOLD + 8;
        if (kind == "V") return 18 * (int'(p2) + 1) + 8;
        return 2 * RST_HOLD + 8;
    endfunction

    task automatic read_cases();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  k;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("mister_frame_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open mister_frame_cases.txt");
            tb_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            a = '0;
            b = '0;
            n = $fgets(line, fd);
            if (n > 0 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h", k, a, b);
                if (n >= 1 && (k == "D" || k == "V" || k == "R")) begin
                    case_kind.push_back(k);
                    case_p1.push_back(a);
                    case_p2.push_back(b);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_game_run();
        int n;
        n = 0;
        while (game_rst_n !== 1'b1 && n < 4 * RST_HOLD) begin
            @(negedge clk_sys);
            n++;
        end
        if (game_rst_n !== 1'b1) begin
            $display("Game reset was not released within %0d cycles", n);
            tb_errors++;
        end
    endtask

    task automatic load_rom(input logic [31:0] start, input logic [31:0] count);
        logic [31:0] rnd;
        @(negedge clk_sys);
        downloading = 1'b1;
        for (int i = 0; i < int'(count); i++) begin
            @(negedge clk_sys);
            rnd        = $urandom();
            ioctl.addr = ROM_AW'(start + 32'(i));
            ioctl.data = rnd[7:0];
            ioctl.wr   = 1'b1;
            @(negedge clk_sys);
            ioctl.wr   = 1'b0;      // Strobes two cycles apart
        end
        @(negedge clk_sys);
        downloading = 1'b0;
        wait_game_run();
    endtask

    task automatic show_frame(input logic [1:0] level, input logic [31:0] lines);
        logic [31:0] rnd;
        rnd    = $urandom();
        status = rnd;       // Other status bits must not matter
        status[STATUS_FX_LSB +: 2] = level;
        for (int l = -1; l < int'(lines); l++) begin
            for (int c = 0; c < 18; c++) begin
                @(negedge clk_sys);
                rnd       = $urandom();
                game.r    = rnd[3:0];
                game.g    = rnd[7:4];
                game.b    = rnd[11:8];
                game.vs   = (l < 0) && (c < 3);   // Line -1 is the vsync line
                game.hs   = (c < 2);
                game.lhbl = (c >= 4) && (c < 16);
                game.lvbl = (l >= 0);
                pxl_cen   = ~pxl_cen;
            end
        end
        @(negedge clk_sys);
        game   = '0;
        status = '0;
    endtask

    task automatic request_reset();
        @(negedge clk_sys);
        rst_req = 1'b1;
        @(negedge clk_sys);
        rst_req = 1'b0;
        @(negedge clk_sys);
        if (game_rst_n !== 1'b0) begin
            $display("Game reset did not drop after the reset request");
            tb_errors++;
        end
        wait_game_run();
    endtask

    initial begin
        wait (limit_cycles > 0);
        #(limit_cycles * 20);
        $display("Timeout, the run did not finish within %0d cycles", limit_cycles);
        $display("Errors found");
        $finish;
    end

    initial begin
        int errs_before;
        int n_pass;
        int n_fail;
        int budget;
        void'($urandom(18171));
        rst_n       = 1'b0;
        ioctl       = '0;
        downloading = 1'b0;
        rst_req     = 1'b0;
        status      = '0;
        pxl_cen     = 1'b0;
        game        = '0;
        n_pass      = 0;
        n_fail      = 0;
        read_cases();
        budget = 200;
        foreach (case_kind[i]) budget += case_cycles(case_kind[i], case_p2[i]);
        limit_cycles = budget;      // One write starts the watchdog with the full budget
        repeat (3) @(negedge clk_sys);
        rst_n = 1'b1;
        foreach (case_kind[i]) begin
            errs_before = error_total();
            wait_game_run();
            case (case_kind[i])
                "D":     load_rom(case_p1[i], case_p2[i]);
                "V":     show_frame(case_p1[i][1:0], case_p2[i]);
                default: request_reset();
            endcase
            repeat (2) @(negedge clk_sys);     // Let the monitor see the last outputs
            if (error_total() == errs_before) begin
                n_pass++;
                $display("Case %0d (%c) passed", i, case_kind[i]);
            end else begin
                n_fail++;
                $display("Case %0d (%c) failed", i, case_kind[i]);
            end
        end
        $display("%0d cases passed, %0d failed, %0d errors", n_pass, n_fail, error_total());
        if (n_fail == 0 && error_total() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds and runs the mister_frame testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mister_frame_tb -f mister_frame.f -o mister_frame_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mister_frame_sim +verilator+error+limit+1000 > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "No errors" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
